// File: calc_macros.svh
// Calculator width and radix
`ifndef CALC_MACROS_SVH
`define CALC_MACROS_SVH

// Full operand word with the sign bit
`define CALC_WIDTH 16

// Magnitude field below the sign bit
`define CALC_MAG_W (`CALC_WIDTH - 1)

// Keypad entry is decimal
`define CALC_RADIX 10

`endif

// File: calc_pkg.sv
// Calculator shared types
`include "calc_macros.svh"

package calc_pkg;

    // Sign-magnitude operand
    typedef struct packed {
        logic                   sign;
        logic [`CALC_MAG_W-1:0] mag;
    } calc_num_t;

    // Codes 5 to 7 are unused
    typedef enum logic [2:0] {
        OP_NONE = 3'd0,
        OP_NEG  = 3'd1,
        OP_ADD  = 3'd2,
        OP_SUB  = 3'd3,
        OP_MUL  = 3'd4
    } calc_oper_t;

    typedef struct packed {
        calc_num_t a;
        calc_num_t b;
        logic      sub;
    } addsub_req_t;

    typedef struct packed {
        calc_num_t a;
        calc_num_t b;
    } mult_req_t;

    // Shared by both arithmetic units
    typedef struct packed {
        calc_num_t result;
        logic      finish;
    } arith_rsp_t;

endpackage

// File: calc_addsub.sv
// Sign-magnitude adder and subtractor
`timescale 1ns/1ps
`include "calc_macros.svh"

module calc_addsub (
    input  logic                    clk,
    input  logic                    nRST,
    input  calc_pkg::addsub_req_t   req,
    input  logic                    start,
    output calc_pkg::arith_rsp_t    rsp
);

    localparam int MAG_W = `CALC_MAG_W;

    logic               b_sign;
    logic               sum_sign;
    logic [MAG_W-1:0]   sum_mag;
    logic               finish_q;
    calc_pkg::calc_num_t result_q;

    // Subtract is add with the second sign flipped
    assign b_sign = req.b.sign ^ req.sub;

    always_comb begin
        if (req.a.sign == b_sign) begin
            sum_mag  = req.a.mag + req.b.mag;
            sum_sign = req.a.sign;
        end else if (req.a.mag >= req.b.mag) begin
            sum_mag  = req.a.mag - req.b.mag;
            sum_sign = req.a.sign;
        end else begin
            sum_mag  = req.b.mag - req.a.mag;
            sum_sign = b_sign;
        end
        // No negative zero
        if (sum_mag == '0) begin
            sum_sign = 1'b0;
        end
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            finish_q <= 1'b0;
        end else begin
            finish_q <= start;
        end
    end

    // Result held until the next start
    always_ff @(posedge clk) begin
        if (start) begin
            result_q.sign <= sum_sign;
            result_q.mag  <= sum_mag;
        end
    end

    assign rsp = '{result: result_q, finish: finish_q};

endmodule

// File: calc_multiplier.sv
// Sequential shift-and-add multiplier
`timescale 1ns/1ps
`include "calc_macros.svh"

module calc_multiplier (
    input  logic                    clk,
    input  logic                    nRST,
    input  calc_pkg::mult_req_t     req,
    input  logic                    start,
    output calc_pkg::arith_rsp_t    rsp
);

    localparam int MAG_W = `CALC_MAG_W;
    localparam int CNT_W = $clog2(MAG_W);

    logic                busy;
    logic                finish_q;
    logic [CNT_W-1:0]    count;
    logic [MAG_W-1:0]    mcand;
    logic [MAG_W-1:0]    mplier;
    logic [MAG_W-1:0]    acc;
    logic [MAG_W-1:0]    acc_next;
    logic                sign_q;
    logic                last_step;
    calc_pkg::calc_num_t result_q;

    // Upper product bits fall off the top
    assign acc_next  = mplier[0] ? acc + mcand : acc;
    assign last_step = (count == CNT_W'(MAG_W - 1));

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            busy     <= 1'b0;
            count    <= '0;
            finish_q <= 1'b0;
        end else begin
            finish_q <= 1'b0;
            if (busy) begin
                count <= count + 1'b1;
                if (last_step) begin
                    busy     <= 1'b0;
                    finish_q <= 1'b1;
                end
            end else if (start) begin
                busy  <= 1'b1;
                count <= '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (busy) begin
            acc    <= acc_next;
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
            if (last_step) begin
                result_q.sign <= sign_q && (acc_next != '0);
                result_q.mag  <= acc_next;
            end
        end else if (start) begin
            acc    <= '0;
            mcand  <= req.a.mag;
            mplier <= req.b.mag;
            sign_q <= req.a.sign ^ req.b.sign;
        end
    end

    assign rsp = '{result: result_q, finish: finish_q};

    no_start_while_busy: assert property (
        @(posedge clk) disable iff (!nRST) start |-> !busy
    ) else $error("multiplier started while busy");

    // Fixed latency from start to finish
    finish_latency: assert property (
        @(posedge clk) disable iff (!nRST) start |-> ##(MAG_W + 1) rsp.finish
    ) else $error("multiplier finish latency wrong");

endmodule

// File: calc_control.sv
// Calculator entry and compute control
`timescale 1ns/1ps
`include "calc_macros.svh"

module calc_control (
    input  logic                    clk,
    input  logic                    nRST,
    input  logic [3:0]              keypad_input,
    input  logic                    read_input,
    input  logic                    equal_input,
    input  calc_pkg::calc_oper_t    operator_input,
    output logic                    key_read,
    output logic                    complete,
    output calc_pkg::calc_num_t     display_output,
    output calc_pkg::addsub_req_t   add_req,
    output logic                    add_start,
    input  calc_pkg::arith_rsp_t    add_rsp,
    output calc_pkg::mult_req_t     mul_req,
    output logic                    mul_start,
    input  calc_pkg::arith_rsp_t    mul_rsp
);

    localparam int MAG_W = `CALC_MAG_W;

    localparam calc_pkg::calc_num_t RADIX_NUM = '{sign: 1'b0, mag: MAG_W'(`CALC_RADIX)};

    typedef enum logic [3:0] {
        S_WAIT_FIRST,
        S_MUL_FIRST,
        S_ADD_FIRST,
        S_WAIT_SECOND,
        S_MUL_SECOND,
        S_ADD_SECOND,
        S_SEND,
        S_WAIT_COMPUTE,
        S_SHOW
    } state_t;

    state_t               state_q;
    state_t               state_d;
    calc_pkg::calc_num_t  op_a;
    calc_pkg::calc_num_t  op_b;
    calc_pkg::calc_num_t  cur_op;
    calc_pkg::calc_oper_t oper_q;
    calc_pkg::arith_rsp_t unit_rsp;
    logic [3:0]           digit_q;
    logic                 in_wait;
    logic                 second;
    logic                 digit_acc;
    logic                 neg_acc;
    logic                 op_acc;
    logic                 eq_acc;
    logic                 press_acc;

    assign second  = (state_q == S_WAIT_SECOND);
    assign in_wait = (state_q == S_WAIT_FIRST) || second;
    assign cur_op  = second ? op_b : op_a;

    // Press decode giving digits priority
    assign digit_acc = in_wait && read_input;
    assign eq_acc    = second && !read_input && equal_input;
    assign neg_acc   = in_wait && !read_input && !equal_input
                       && (operator_input == calc_pkg::OP_NEG);
    assign op_acc    = (state_q == S_WAIT_FIRST) && !read_input && !equal_input
                       && (operator_input inside {calc_pkg::OP_ADD, calc_pkg::OP_SUB,
                                                  calc_pkg::OP_MUL});
    assign press_acc = digit_acc || eq_acc || neg_acc || op_acc;

    // Unit picked by the latched operator
    assign unit_rsp = (oper_q == calc_pkg::OP_MUL) ? mul_rsp : add_rsp;

    always_comb begin
        state_d = state_q;
        case (state_q)
            S_WAIT_FIRST: begin
                if (digit_acc) begin
                    state_d = S_MUL_FIRST;
                end else if (op_acc) begin
                    state_d = S_WAIT_SECOND;
                end
            end
            S_MUL_FIRST: begin
                if (mul_rsp.finish) begin
                    state_d = S_ADD_FIRST;
                end
            end
            S_ADD_FIRST: state_d = S_WAIT_FIRST;
            S_WAIT_SECOND: begin
                if (digit_acc) begin
                    state_d = S_MUL_SECOND;
                end else if (eq_acc) begin
                    state_d = S_SEND;
                end
            end
            S_MUL_SECOND: begin
                if (mul_rsp.finish) begin
                    state_d = S_ADD_SECOND;
                end
            end
            S_ADD_SECOND: state_d = S_WAIT_SECOND;
            S_SEND: state_d = S_WAIT_COMPUTE;
            S_WAIT_COMPUTE: begin
                if (unit_rsp.finish) begin
                    state_d = S_SHOW;
                end
            end
            S_SHOW: state_d = S_WAIT_FIRST;
            default: state_d = S_WAIT_FIRST;
        endcase
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            state_q        <= S_WAIT_FIRST;
            key_read       <= 1'b0;
            complete       <= 1'b0;
            display_output <= '0;
            add_start      <= 1'b0;
            mul_start      <= 1'b0;
            op_a           <= '0;
            op_b           <= '0;
            oper_q         <= calc_pkg::OP_NONE;
        end else begin
            state_q   <= state_d;
            key_read  <= press_acc;
            complete  <= 1'b0;
            add_start <= (state_q == S_SEND) && (oper_q != calc_pkg::OP_MUL);
            mul_start <= digit_acc || ((state_q == S_SEND) && (oper_q == calc_pkg::OP_MUL));

            if (neg_acc && !second) begin
                op_a.sign <= ~op_a.sign;
            end
            if (neg_acc && second) begin
                op_b.sign <= ~op_b.sign;
            end
            if (op_acc) begin
                oper_q <= operator_input;
            end

            case (state_q)
                // Product magnitude plus digit with the sign kept
                S_ADD_FIRST:  op_a.mag <= mul_rsp.result.mag + MAG_W'(digit_q);
                S_ADD_SECOND: op_b.mag <= mul_rsp.result.mag + MAG_W'(digit_q);
                S_SHOW: begin
                    complete       <= 1'b1;
                    display_output <= unit_rsp.result;
                    op_a           <= '0;
                    op_b           <= '0;
                    oper_q         <= calc_pkg::OP_NONE;
                end
                default: ;
            endcase
        end
    end

    // Requests line up with the start pulses above
    always_ff @(posedge clk) begin
        if (digit_acc) begin
            digit_q <= keypad_input;
            mul_req <= '{a: cur_op, b: RADIX_NUM};
        end else if ((state_q == S_SEND) && (oper_q == calc_pkg::OP_MUL)) begin
            mul_req <= '{a: op_a, b: op_b};
        end
        if (state_q == S_SEND) begin
            add_req <= '{a: op_a, b: op_b, sub: (oper_q == calc_pkg::OP_SUB)};
        end
    end

    one_unit_at_a_time: assert property (
        @(posedge clk) disable iff (!nRST) !(add_start && mul_start)
    ) else $error("add and multiply started together");

endmodule

// File: calc_top.sv
// Keypad calculator top level
`timescale 1ns/1ps

module calc_top (
    input  logic                    clk,
    input  logic                    nRST,
    input  logic [3:0]              keypad_input,
    input  logic                    read_input,
    input  calc_pkg::calc_oper_t    operator_input,
    input  logic                    equal_input,
    output logic                    key_read,
    output logic                    complete,
    output calc_pkg::calc_num_t     display_output
);

    calc_pkg::addsub_req_t add_req;
    calc_pkg::mult_req_t   mul_req;
    calc_pkg::arith_rsp_t  add_rsp;
    calc_pkg::arith_rsp_t  mul_rsp;
    logic                  add_start;
    logic                  mul_start;

    calc_control control_i (
        .clk            (clk),
        .nRST           (nRST),
        .keypad_input   (keypad_input),
        .read_input     (read_input),
        .equal_input    (equal_input),
        .operator_input (operator_input),
        .key_read       (key_read),
        .complete       (complete),
        .display_output (display_output),
        .add_req        (add_req),
        .add_start      (add_start),
        .add_rsp        (add_rsp),
        .mul_req        (mul_req),
        .mul_start      (mul_start),
        .mul_rsp        (mul_rsp)
    );

    calc_addsub addsub_i (
        .clk   (clk),
        .nRST  (nRST),
        .req   (add_req),
        .start (add_start),
        .rsp   (add_rsp)
    );

    // Shared by digit entry and the multiply operator
    calc_multiplier mult_i (
        .clk   (clk),
        .nRST  (nRST),
        .req   (mul_req),
        .start (mul_start),
        .rsp   (mul_rsp)
    );

endmodule

// File: calc_tb.sv
// Keypad calculator testbench
`timescale 1ns/1ps
`include "calc_macros.svh"

module calc_tb;

    localparam int     MAG_W          = `CALC_MAG_W;
    localparam longint MAG_MOD        = 64'd1 << `CALC_MAG_W;
    localparam int     PRESS_TIMEOUT  = 80;
    localparam int     ACK_WINDOW     = 2;
    localparam int     IGNORE_WINDOW  = 30;
    localparam int     RESULT_TIMEOUT = 100;

    // First digit sits in the highest used nibble
    typedef struct packed {
        logic [31:0] digits;
        logic [3:0]  count;
        logic        neg;
    } entry_t;

    logic                 clk;
    logic                 nRST;
    logic [3:0]           keypad_input;
    logic                 read_input;
    calc_pkg::calc_oper_t operator_input;
    logic                 equal_input;
    logic                 key_read;
    logic                 complete;
    calc_pkg::calc_num_t  display_output;

    calc_pkg::calc_num_t  expected_q[$];
    calc_pkg::calc_num_t  check_exp;
    int                   calcs_started;
    int                   checks_done;

    calc_top dut_i (
        .clk            (clk),
        .nRST           (nRST),
        .keypad_input   (keypad_input),
        .read_input     (read_input),
        .operator_input (operator_input),
        .equal_input    (equal_input),
        .key_read       (key_read),
        .complete       (complete),
        .display_output (display_output)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    function automatic longint fold_digits(input entry_t e);
        longint mag;
        int     i;
        mag = 0;
        for (i = int'(e.count) - 1; i >= 0; i--) begin
            mag = (mag * `CALC_RADIX + longint'(e.digits[4*i +: 4])) % MAG_MOD;
        end
        return mag;
    endfunction

    function automatic calc_pkg::calc_num_t calc_model(input entry_t a, input entry_t b,
                                                       input calc_pkg::calc_oper_t oper);
        longint              a_val;
        longint              b_val;
        longint              res;
        longint              mag;
        calc_pkg::calc_num_t num;
        a_val = fold_digits(a);
        b_val = fold_digits(b);
        if (oper == calc_pkg::OP_MUL) begin
            mag      = (a_val * b_val) % MAG_MOD;
            num.sign = (a.neg ^ b.neg) && (mag != 0);
        end else begin
            if (a.neg) begin
                a_val = -a_val;
            end
            if (b.neg) begin
                b_val = -b_val;
            end
            res      = (oper == calc_pkg::OP_SUB) ? a_val - b_val : a_val + b_val;
            mag      = (res < 0 ? -res : res) % MAG_MOD;
            num.sign = (res < 0) && (mag != 0);
        end
        num.mag = MAG_W'(mag);
        return num;
    endfunction

    function automatic entry_t make_entry(input logic [31:0] digits, input int count,
                                          input logic neg);
        entry_t e;
        e.digits = digits;
        e.count  = 4'(count);
        e.neg    = neg;
        return e;
    endfunction

    function automatic entry_t random_entry(input int min_count, input int max_count);
        entry_t e;
        int     i;
        e.digits = '0;
        e.count  = 4'($urandom_range(max_count, min_count));
        for (i = 0; i < int'(e.count); i++) begin
            e.digits[4*i +: 4] = 4'($urandom_range(9, 0));
        end
        e.neg = 1'($urandom_range(1, 0));
        return e;
    endfunction

    // Re-pulses while control is busy until key_read or timeout
    task automatic drive_press(input logic rd, input logic [3:0] digit,
                               input calc_pkg::calc_oper_t oper, input logic eq,
                               input string what);
        int waited;
        int since_pulse;
        bit acked;
        waited = 0;
        acked  = 1'b0;
        while (!acked) begin
            @(posedge clk);
            keypad_input   <= digit;
            read_input     <= rd;
            operator_input <= oper;
            equal_input    <= eq;
            @(posedge clk);
            read_input     <= 1'b0;
            operator_input <= calc_pkg::OP_NONE;
            equal_input    <= 1'b0;
            waited      = waited + 2;
            since_pulse = 0;
            while (!acked && since_pulse < ACK_WINDOW) begin
                @(posedge clk);
                since_pulse++;
                waited++;
                acked = key_read;
            end
            assert (acked || waited < PRESS_TIMEOUT)
            else report_failure({what, " got no key_read before the timeout"});
        end
    endtask

    task automatic press_digit(input logic [3:0] digit);
        drive_press(1'b1, digit, calc_pkg::OP_NONE, 1'b0, "digit press");
    endtask

    task automatic press_op(input calc_pkg::calc_oper_t oper);
        drive_press(1'b0, 4'd0, oper, 1'b0, "operator press");
    endtask

    task automatic press_equal();
        drive_press(1'b0, 4'd0, calc_pkg::OP_NONE, 1'b1, "equal press");
    endtask

    task automatic press_expect_ignored(input logic eq, input calc_pkg::calc_oper_t oper,
                                        input string what);
        int cycles;
        @(posedge clk);
        operator_input <= oper;
        equal_input    <= eq;
        @(posedge clk);
        operator_input <= calc_pkg::OP_NONE;
        equal_input    <= 1'b0;
        for (cycles = 0; cycles < IGNORE_WINDOW; cycles++) begin
            @(posedge clk);
            assert (!key_read)
            else report_failure({what, " was acknowledged but should be ignored"});
        end
    endtask

    task automatic wait_result();
        int cycles;
        cycles = 0;
        @(posedge clk);
        while (!complete && cycles < RESULT_TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        assert (complete)
        else report_failure("no complete pulse arrived after equal before the timeout");
    endtask

    // Negate goes in at a random point among the digits
    task automatic enter_operand(input entry_t e);
        int neg_pos;
        int k;
        neg_pos = $urandom_range(int'(e.count), 0);
        for (k = 0; k <= int'(e.count); k++) begin
            if (e.neg && k == neg_pos) begin
                press_op(calc_pkg::OP_NEG);
            end
            if (k < int'(e.count)) begin
                press_digit(e.digits[4*(int'(e.count) - 1 - k) +: 4]);
            end
        end
    endtask

    task automatic run_calc(input entry_t a, input entry_t b,
                            input calc_pkg::calc_oper_t oper, input bit stray);
        calc_pkg::calc_oper_t stray_code;
        enter_operand(a);
        press_op(oper);
        if (stray) begin
            stray_code = calc_pkg::calc_oper_t'(3'(2 + $urandom_range(5, 0)));
            press_expect_ignored(1'b0, stray_code, "operator press in the second operand");
        end
        enter_operand(b);
        expected_q.push_back(calc_model(a, b, oper));
        calcs_started++;
        press_equal();
        wait_result();
    endtask

    function automatic calc_pkg::calc_oper_t random_oper(input bit with_mul);
        return calc_pkg::calc_oper_t'(3'(2 + $urandom_range(with_mul ? 2 : 1, 0)));
    endfunction

    always @(posedge clk) begin
        if (nRST && complete) begin
            assert (expected_q.size() > 0)
            else report_failure("complete pulsed with no calculation pending");
            check_exp = expected_q.pop_front();
            assert (display_output == check_exp)
            else report_failure($sformatf(
                "error at %0d ns: display_output expected %h actual %h",
                $time, check_exp, display_output));
            checks_done++;
        end
    end

    initial begin
        int n;
        void'($urandom(32'h2693_3728));
        nRST           = 1'b0;
        keypad_input   = 4'd0;
        read_input     = 1'b0;
        operator_input = calc_pkg::OP_NONE;
        equal_input    = 1'b0;
        calcs_started  = 0;
        checks_done    = 0;
        repeat (3) @(posedge clk);
        nRST <= 1'b1;

        // Quiet outputs after reset
        for (n = 0; n < 10; n++) begin
            @(posedge clk);
            assert (key_read == 1'b0)
            else report_failure($sformatf("error at %0d ns: key_read expected 0 actual %b",
                                          $time, key_read));
            assert (complete == 1'b0)
            else report_failure($sformatf("error at %0d ns: complete expected 0 actual %b",
                                          $time, complete));
            assert (display_output == '0)
            else report_failure($sformatf(
                "error at %0d ns: display_output expected 0000 actual %h",
                $time, display_output));
        end

        // Add and subtract
        run_calc(make_entry(32'h12, 2, 0), make_entry(32'h345, 3, 0), calc_pkg::OP_SUB, 0);
        run_calc(make_entry(32'h123, 3, 0), make_entry(32'h123, 3, 0), calc_pkg::OP_SUB, 0);
        run_calc(make_entry(32'h45, 2, 1), make_entry(32'h45, 2, 1), calc_pkg::OP_SUB, 0);
        run_calc(make_entry(32'h7, 1, 1), make_entry(32'h7, 1, 0), calc_pkg::OP_ADD, 0);
        run_calc(make_entry(32'h1200, 4, 1), make_entry(32'h34, 2, 0), calc_pkg::OP_ADD, 0);
        for (n = 0; n < 20; n++) begin
            run_calc(random_entry(1, 4), random_entry(1, 4), random_oper(0), 0);
        end

        // Multiply
        run_calc(make_entry(32'h123, 3, 0), make_entry(32'h456, 3, 0), calc_pkg::OP_MUL, 0);
        run_calc(make_entry(32'h7, 1, 1), make_entry(32'h9, 1, 0), calc_pkg::OP_MUL, 0);
        run_calc(make_entry(32'h12, 2, 1), make_entry(32'h12, 2, 1), calc_pkg::OP_MUL, 0);
        run_calc(make_entry(32'h9999, 4, 0), make_entry(32'h9999, 4, 1), calc_pkg::OP_MUL, 0);
        run_calc(make_entry(32'h5, 1, 1), make_entry(32'h0, 1, 0), calc_pkg::OP_MUL, 0);
        for (n = 0; n < 20; n++) begin
            run_calc(random_entry(1, 4), random_entry(1, 4), calc_pkg::OP_MUL, 0);
        end

        // Long entries wrap
        run_calc(make_entry(32'h99999, 5, 0), make_entry(32'h0, 1, 0), calc_pkg::OP_ADD, 0);
        run_calc(make_entry(32'h12345678, 8, 0), make_entry(32'h1, 1, 0), calc_pkg::OP_MUL, 0);
        for (n = 0; n < 10; n++) begin
            run_calc(random_entry(5, 8), random_entry(1, 8), random_oper(1), 0);
        end

        // Presses outside an accepting state
        press_expect_ignored(1'b1, calc_pkg::OP_NONE, "equal press before any operator");
        run_calc(make_entry(32'h321, 3, 0), make_entry(32'h21, 2, 1), calc_pkg::OP_SUB, 0);
        for (n = 0; n < 6; n++) begin
            run_calc(random_entry(1, 4), random_entry(1, 4), random_oper(1), 1);
        end

        // Back to back with empty operands included
        for (n = 0; n < 200; n++) begin
            run_calc(random_entry(0, 4), random_entry(0, 4), random_oper(1), 0);
        end

        repeat (2) @(posedge clk);
        if (expected_q.size() == 0 && checks_done == calcs_started) begin
            $display("ALL CHECKS PASSED");
            $finish;
        end else begin
            report_failure($sformatf("%0d calculations started but %0d results checked",
                                     calcs_started, checks_done));
        end
    end

endmodule

// File: all.f
+incdir+.
calc_pkg.sv
calc_addsub.sv
calc_multiplier.sv
calc_control.sv
calc_top.sv
calc_tb.sv

// File: Bender.yml
package:
  name: calc

sources:
  - include_dirs:
      - .
    files:
      - calc_pkg.sv
      - calc_addsub.sv
      - calc_multiplier.sv
      - calc_control.sv
      - calc_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - calc_tb.sv
